// ==== Makefile ====
TOP := tb_lsu_tile_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f files.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/load_packer.sv
hw/lsu.sv
hw/dmem.sv
hw/remote_req_tx.sv
hw/lsu_tile_top.sv
verif/remote_mem_model.sv
verif/tb_lsu_tile_top.sv

// ==== hw/dmem.sv ====
// tile data memory
// byte-masked word writes, registered load result packed one cycle later

`default_nettype none

`include "lsu_defs.svh"

module dmem
  import lsu_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,

  input  wire logic                         v_i,
  input  wire logic                         w_i,
  input  wire logic [`DMEM_ADDR_WIDTH-1:0]  addr_i,
  input  wire logic [`DATA_WIDTH-1:0]       data_i,
  input  wire logic [`DATA_MASK_WIDTH-1:0]  mask_i,
  input  wire load_info_s                   load_info_i,

  output logic      [`DATA_WIDTH-1:0]       load_data_o,
  output logic                              load_v_o,
  output logic      [`REG_ADDR_WIDTH-1:0]   load_reg_o,
  output logic                              load_float_o
);

  localparam int DEPTH = 1 << `DMEM_ADDR_WIDTH;

  logic [`DATA_WIDTH-1:0] mem_r [DEPTH];
  logic [`DATA_WIDTH-1:0] rd_word_r;
  load_info_s             rd_info_r;
  logic                   rd_v_r;

  // write lanes and read port
  always_ff @(posedge clk_i) begin
    if (v_i & w_i) begin
      for (int b = 0; b < `DATA_MASK_WIDTH; b++) begin
        if (mask_i[b]) begin
          mem_r[addr_i][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end
    if (v_i & ~w_i) begin
      rd_word_r <= mem_r[addr_i];
      rd_info_r <= load_info_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_v_r <= 1'b0;
    end else begin
      rd_v_r <= v_i & ~w_i;
    end
  end

  // align and extend after the register
  load_packer local_packer (
    .mem_data_i      (rd_word_r),
    .unsigned_load_i (rd_info_r.is_unsigned_op),
    .byte_load_i     (rd_info_r.is_byte_op),
    .hex_load_i      (rd_info_r.is_hex_op),
    .part_sel_i      (rd_info_r.part_sel),
    .load_data_o     (load_data_o)
  );

  assign load_v_o     = rd_v_r;
  assign load_reg_o   = rd_info_r.reg_id;
  assign load_float_o = rd_info_r.float_wb;

endmodule

`default_nettype wire

// ==== hw/load_packer.sv ====
// load data packer
// picks the byte or halfword lane of a loaded word and extends it

`default_nettype none

`include "lsu_defs.svh"

module load_packer (
  input  wire logic [`DATA_WIDTH-1:0] mem_data_i,
  input  wire logic                   unsigned_load_i,
  input  wire logic                   byte_load_i,
  input  wire logic                   hex_load_i,
  input  wire logic [1:0]             part_sel_i,
  output logic      [`DATA_WIDTH-1:0] load_data_o
);

  logic [7:0]  byte_field;
  logic [15:0] hex_field;
  logic        byte_sign;
  logic        hex_sign;

  // lane select, halfwords use the upper part_sel bit only
  assign byte_field = mem_data_i[{part_sel_i, 3'b000} +: 8];
  assign hex_field  = mem_data_i[{part_sel_i[1], 4'b0000} +: 16];

  assign byte_sign = byte_field[7] & ~unsigned_load_i;
  assign hex_sign  = hex_field[15] & ~unsigned_load_i;

  always_comb begin
    if (byte_load_i) begin
      load_data_o = {{(`DATA_WIDTH-8){byte_sign}}, byte_field};
    end else if (hex_load_i) begin
      load_data_o = {{(`DATA_WIDTH-16){hex_sign}}, hex_field};
    end else begin
      load_data_o = mem_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsu.sv ====
// load/store unit
// address generation, store lane data and mask, local/remote routing
// and steering of remote load responses to the write-back ports

`default_nettype none

`include "lsu_defs.svh"

module lsu
  import lsu_pkg::*;
(
  // from execute
  input  wire decode_s                        exe_decode_i,
  input  wire logic [`DATA_WIDTH-1:0]         exe_rs1_i,
  input  wire logic [`DATA_WIDTH-1:0]         exe_rs2_i,
  input  wire logic [`REG_ADDR_WIDTH-1:0]     exe_rd_i,
  input  wire logic [`DATA_WIDTH-1:0]         mem_offset_i,

  // to local dmem
  output logic                                dmem_v_o,
  output logic                                dmem_w_o,
  output logic      [`DMEM_ADDR_WIDTH-1:0]    dmem_addr_o,
  output logic      [`DATA_WIDTH-1:0]         dmem_data_o,
  output logic      [`DATA_MASK_WIDTH-1:0]    dmem_mask_o,
  output load_info_s                          dmem_load_info_o,

  // to network tx
  output remote_req_s                         remote_req_o,
  output logic                                remote_req_v_o,

  // remote load responses
  input  wire remote_load_resp_s              net_resp_i,
  input  wire logic                           net_resp_v_i,
  input  wire logic                           resp_force_i,
  output logic                                net_resp_yumi_o,

  // float write-back
  output logic      [`DATA_WIDTH-1:0]         fp_remote_load_data_o,
  output logic                                fp_remote_load_v_o,

  // integer write-back
  output logic      [`DATA_WIDTH-1:0]         int_remote_load_data_o,
  output logic                                int_remote_load_v_o,
  output logic                                int_remote_load_force_o,
  input  wire logic                           int_remote_load_yumi_i
);

  localparam int BYTE_OFS_W = $clog2(`DATA_MASK_WIDTH);
  localparam int LOCAL_TOP  = BYTE_OFS_W + `DMEM_ADDR_WIDTH;

  logic [`DATA_WIDTH-1:0]      mem_addr;
  logic [`DATA_WIDTH-1:0]      store_data;
  logic [`DATA_MASK_WIDTH-1:0] store_mask;
  logic                        is_local;
  load_info_s                  load_info;
  payload_u                    payload;
  logic                        resp_is_fp;

  assign mem_addr = exe_rs1_i + mem_offset_i;

  // replicate store data so every lane holds it, the mask picks the lane
  always_comb begin
    if (exe_decode_i.is_byte_op) begin
      store_data = {`DATA_MASK_WIDTH{exe_rs2_i[7:0]}};
      store_mask = `DATA_MASK_WIDTH'(1) << mem_addr[BYTE_OFS_W-1:0];
    end else if (exe_decode_i.is_hex_op) begin
      store_data = {(`DATA_MASK_WIDTH/2){exe_rs2_i[15:0]}};
      store_mask = `DATA_MASK_WIDTH'(2'b11) << {mem_addr[1], 1'b0};
    end else begin
      store_data = exe_rs2_i;
      store_mask = '1;
    end
  end

  always_comb begin
    load_info.float_wb       = exe_decode_i.op_writes_fp_rf;
    load_info.is_unsigned_op = exe_decode_i.is_load_unsigned;
    load_info.is_byte_op     = exe_decode_i.is_byte_op;
    load_info.is_hex_op      = exe_decode_i.is_hex_op;
    load_info.part_sel       = mem_addr[1:0];
    load_info.reg_id         = exe_rd_i;
  end

  // local when nothing is set above the dmem word range
  assign is_local = (mem_addr[`DATA_WIDTH-1:LOCAL_TOP] == '0);

  assign dmem_v_o         = exe_decode_i.is_mem_op & is_local;
  assign dmem_w_o         = exe_decode_i.is_store_op;
  assign dmem_addr_o      = mem_addr[BYTE_OFS_W +: `DMEM_ADDR_WIDTH];
  assign dmem_data_o      = store_data;
  assign dmem_mask_o      = store_mask;
  assign dmem_load_info_o = load_info;

  always_comb begin
    if (exe_decode_i.is_load_op) begin
      payload.read_info.reserved  = '0;
      payload.read_info.load_info = load_info;
    end else begin
      payload.write_data = store_data;
    end
  end

  always_comb begin
    remote_req_o.write_not_read = exe_decode_i.is_store_op;
    remote_req_o.mask           = store_mask;
    remote_req_o.addr           = mem_addr;
    remote_req_o.payload        = payload;
  end

  assign remote_req_v_o = exe_decode_i.is_mem_op & ~is_local;

  // integer responses are packed here, float ones go out raw
  load_packer remote_packer (
    .mem_data_i      (net_resp_i.data),
    .unsigned_load_i (net_resp_i.is_unsigned_op),
    .byte_load_i     (net_resp_i.is_byte_op),
    .hex_load_i      (net_resp_i.is_hex_op),
    .part_sel_i      (net_resp_i.part_sel),
    .load_data_o     (int_remote_load_data_o)
  );

  assign fp_remote_load_data_o = net_resp_i.data;
  assign resp_is_fp            = net_resp_i.float_wb;

  assign fp_remote_load_v_o  = net_resp_v_i & resp_is_fp;
  assign int_remote_load_v_o = net_resp_v_i & ~resp_is_fp;

  // force drains the response even when execute cannot take it
  assign int_remote_load_force_o = int_remote_load_v_o & resp_force_i
                                   & ~int_remote_load_yumi_i;

  assign net_resp_yumi_o = fp_remote_load_v_o
                         | (int_remote_load_v_o & (int_remote_load_yumi_i | resp_force_i));

endmodule

`default_nettype wire

// ==== hw/lsu_defs.svh ====
// load/store path parameters
// word width, local memory depth, register index width and network credits

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// one data word
`define DATA_WIDTH 32

// byte lanes per word
`define DATA_MASK_WIDTH (`DATA_WIDTH/8)

// local dmem word address, 1024 words = 4 KiB
`define DMEM_ADDR_WIDTH 10

// destination register index
`define REG_ADDR_WIDTH 5

// credits held by the tile after reset
`define NET_CREDITS 4

`endif

// ==== hw/lsu_pkg.sv ====
// load/store path types
// decode flags, load info, request payload and network packets

`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

  // memory-op flags of the instruction in execute
  typedef struct packed {
    logic is_mem_op;
    logic is_load_op;
    logic is_store_op;
    logic is_byte_op;
    logic is_hex_op;
    logic is_load_unsigned;
    logic op_writes_fp_rf;
  } decode_s;

  // carried with a load until its data comes back
  typedef struct packed {
    logic float_wb;
    logic is_unsigned_op;
    logic is_byte_op;
    logic is_hex_op;
    logic [1:0] part_sel;
    logic [`REG_ADDR_WIDTH-1:0] reg_id;
  } load_info_s;

  // load view of the payload word
  typedef struct packed {
    logic [`DATA_WIDTH-$bits(load_info_s)-1:0] reserved;
    load_info_s load_info;
  } read_info_s;

  // loads send their info, stores send data
  typedef union packed {
    read_info_s read_info;
    logic [`DATA_WIDTH-1:0] write_data;
  } payload_u;

  // request toward the network
  typedef struct packed {
    logic write_not_read;
    logic [`DATA_MASK_WIDTH-1:0] mask;
    logic [`DATA_WIDTH-1:0] addr;
    payload_u payload;
  } remote_req_s;

  // load response from the network
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    logic float_wb;
    logic is_unsigned_op;
    logic is_byte_op;
    logic is_hex_op;
    logic [1:0] part_sel;
    logic [`REG_ADDR_WIDTH-1:0] reg_id;
  } remote_load_resp_s;

endpackage

`default_nettype wire

// ==== hw/lsu_tile_top.sv ====
// load/store path of one tile
// lsu feeding the local dmem and the network request transmitter

`default_nettype none

`include "lsu_defs.svh"

module lsu_tile_top
  import lsu_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          arst_n_i,

  // execute stage
  input  wire decode_s                       exe_decode_i,
  input  wire logic [`DATA_WIDTH-1:0]        exe_rs1_i,
  input  wire logic [`DATA_WIDTH-1:0]        exe_rs2_i,
  input  wire logic [`REG_ADDR_WIDTH-1:0]    exe_rd_i,
  input  wire logic [`DATA_WIDTH-1:0]        mem_offset_i,
  output logic                               stall_o,

  // local load write-back
  output logic      [`DATA_WIDTH-1:0]        local_load_data_o,
  output logic                               local_load_v_o,
  output logic      [`REG_ADDR_WIDTH-1:0]    local_load_reg_o,
  output logic                               local_load_float_o,

  // network requests
  output remote_req_s                        net_req_o,
  output logic                               net_req_v_o,
  input  wire logic                          net_credit_i,

  // network responses
  input  wire remote_load_resp_s             net_resp_i,
  input  wire logic                          net_resp_v_i,
  output logic                               net_resp_yumi_o,
  input  wire logic                          resp_force_i,

  // remote load write-back
  output logic      [`DATA_WIDTH-1:0]        fp_remote_load_data_o,
  output logic                               fp_remote_load_v_o,
  output logic      [`DATA_WIDTH-1:0]        int_remote_load_data_o,
  output logic                               int_remote_load_v_o,
  output logic                               int_remote_load_force_o,
  input  wire logic                          int_remote_load_yumi_i
);

  logic                         dmem_v;
  logic                         dmem_w;
  logic [`DMEM_ADDR_WIDTH-1:0]  dmem_addr;
  logic [`DATA_WIDTH-1:0]       dmem_data;
  logic [`DATA_MASK_WIDTH-1:0]  dmem_mask;
  load_info_s                   dmem_load_info;
  remote_req_s                  remote_req;
  logic                         remote_req_v;

  lsu lsu_i (
    .exe_decode_i            (exe_decode_i),
    .exe_rs1_i               (exe_rs1_i),
    .exe_rs2_i               (exe_rs2_i),
    .exe_rd_i                (exe_rd_i),
    .mem_offset_i            (mem_offset_i),
    .dmem_v_o                (dmem_v),
    .dmem_w_o                (dmem_w),
    .dmem_addr_o             (dmem_addr),
    .dmem_data_o             (dmem_data),
    .dmem_mask_o             (dmem_mask),
    .dmem_load_info_o        (dmem_load_info),
    .remote_req_o            (remote_req),
    .remote_req_v_o          (remote_req_v),
    .net_resp_i              (net_resp_i),
    .net_resp_v_i            (net_resp_v_i),
    .resp_force_i            (resp_force_i),
    .net_resp_yumi_o         (net_resp_yumi_o),
    .fp_remote_load_data_o   (fp_remote_load_data_o),
    .fp_remote_load_v_o      (fp_remote_load_v_o),
    .int_remote_load_data_o  (int_remote_load_data_o),
    .int_remote_load_v_o     (int_remote_load_v_o),
    .int_remote_load_force_o (int_remote_load_force_o),
    .int_remote_load_yumi_i  (int_remote_load_yumi_i)
  );

  dmem dmem_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .v_i          (dmem_v),
    .w_i          (dmem_w),
    .addr_i       (dmem_addr),
    .data_i       (dmem_data),
    .mask_i       (dmem_mask),
    .load_info_i  (dmem_load_info),
    .load_data_o  (local_load_data_o),
    .load_v_o     (local_load_v_o),
    .load_reg_o   (local_load_reg_o),
    .load_float_o (local_load_float_o)
  );

  remote_req_tx tx_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (remote_req),
    .req_v_i      (remote_req_v),
    .stall_o      (stall_o),
    .net_req_o    (net_req_o),
    .net_req_v_o  (net_req_v_o),
    .net_credit_i (net_credit_i)
  );

endmodule

`default_nettype wire

// ==== hw/remote_req_tx.sv ====
// network request transmitter
// credit counter and registered packet output, stalls when out of credits

`default_nettype none

`include "lsu_defs.svh"

module remote_req_tx
  import lsu_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         arst_n_i,

  input  wire remote_req_s  req_i,
  input  wire logic         req_v_i,
  output logic              stall_o,

  output remote_req_s       net_req_o,
  output logic              net_req_v_o,
  input  wire logic         net_credit_i
);

  localparam int CNT_W = $clog2(`NET_CREDITS + 1);
  localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(`NET_CREDITS);

  logic [CNT_W-1:0] credits_r;
  logic             has_credit;
  logic             send;

  assign has_credit = (credits_r != '0);
  assign send       = req_v_i & has_credit;
  assign stall_o    = req_v_i & ~has_credit;

  // spend on send, refill on credit, both may land together
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_r <= MAX_CREDITS;
    end else if (send & ~net_credit_i) begin
      credits_r <= credits_r - 1'b1;
    end else if (~send & net_credit_i & (credits_r != MAX_CREDITS)) begin
      credits_r <= credits_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      net_req_v_o <= 1'b0;
    end else begin
      net_req_v_o <= send;
    end
  end

  // packet only loads on a send
  always_ff @(posedge clk_i) begin
    if (send) begin
      net_req_o <= req_i;
    end
  end

endmodule

`default_nettype wire

// ==== verif/remote_mem_model.sv ====
// behavioral network and remote memory
// takes request packets, returns credits and answers loads after random delays

`default_nettype none

`include "lsu_defs.svh"

module remote_mem_model
  import lsu_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire remote_req_s        net_req_i,
  input  wire logic               net_req_v_i,
  output logic                    net_credit_o,
  output remote_load_resp_s       net_resp_o,
  output logic                    net_resp_v_o,
  input  wire logic               net_resp_yumi_i,
  input  wire logic               hold_credits_i,
  output logic                    idle_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0]          mem [logic [29:0]];
  int unsigned          credit_due_q [$];
  int unsigned          resp_due_q [$];
  remote_load_resp_s    resp_q [$];
  int unsigned          cycle;
  logic [31:0]          rng;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // unwritten words read back as a pattern of their own address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr[31:2])) begin
      return mem[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    logic [31:0]       word;
    remote_load_resp_s resp;
    if (!arst_n_i) begin
      credit_due_q.delete();
      resp_due_q.delete();
      resp_q.delete();
      cycle        = 0;
      rng          = 32'h8057;
      net_credit_o <= 1'b0;
      net_resp_v_o <= 1'b0;
      net_resp_o   <= '0;
      idle_o       <= 1'b1;
    end else begin
      cycle = cycle + 1;
      if (net_req_v_i) begin
        rng = xorshift(rng);
        credit_due_q.push_back(cycle + 1 + (rng % 4));
        word = read_word(net_req_i.addr);
        if (net_req_i.write_not_read) begin
          for (int b = 0; b < 4; b++) begin
            if (net_req_i.mask[b]) begin
              word[8*b +: 8] = net_req_i.payload.write_data[8*b +: 8];
            end
          end
          mem[net_req_i.addr[31:2]] = word;
        end else begin
          rng                 = xorshift(rng);
          resp.data           = word;
          resp.float_wb       = net_req_i.payload.read_info.load_info.float_wb;
          resp.is_unsigned_op = net_req_i.payload.read_info.load_info.is_unsigned_op;
          resp.is_byte_op     = net_req_i.payload.read_info.load_info.is_byte_op;
          resp.is_hex_op      = net_req_i.payload.read_info.load_info.is_hex_op;
          resp.part_sel       = net_req_i.payload.read_info.load_info.part_sel;
          resp.reg_id         = net_req_i.payload.read_info.load_info.reg_id;
          resp_q.push_back(resp);
          resp_due_q.push_back(cycle + 2 + (rng % 8));
        end
      end

      // one credit per cycle, unless held back
      net_credit_o <= 1'b0;
      if (!hold_credits_i && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
        void'(credit_due_q.pop_front());
        net_credit_o <= 1'b1;
      end

      if (net_resp_v_o && net_resp_yumi_i) begin
        void'(resp_q.pop_front());
        void'(resp_due_q.pop_front());
        net_resp_v_o <= 1'b0;
      end else if (!net_resp_v_o && resp_q.size() != 0 && resp_due_q[0] <= cycle) begin
        net_resp_o   <= resp_q[0];
        net_resp_v_o <= 1'b1;
      end
      idle_o <= (credit_due_q.size() == 0) && (resp_q.size() == 0);
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_lsu_tile_top.sv ====
// testbench for the tile load/store path
// directed tests of local and remote memory ops against a reference model

`default_nettype none

`include "lsu_defs.svh"

module tb_lsu_tile_top
  import lsu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LIMIT = 200;
  // cycle budgets of the six tests plus margin
  localparam int BUDGET = 400 + 150 + 100 + 250 + 100 + 100 + 500;

  logic clk_i, arst_n_i, stall_o, hold_credits, model_idle;
  decode_s exe_decode_i;
  logic [31:0] exe_rs1_i, exe_rs2_i, mem_offset_i;
  logic [4:0] exe_rd_i, local_load_reg_o;
  logic [31:0] local_load_data_o, fp_remote_load_data_o, int_remote_load_data_o;
  logic local_load_v_o, local_load_float_o, net_req_v_o, net_credit_i;
  logic net_resp_v_i, net_resp_yumi_o, resp_force_i, fp_remote_load_v_o;
  logic int_remote_load_v_o, int_remote_load_force_o, int_remote_load_yumi_i;
  remote_req_s net_req_o;
  remote_load_resp_s net_resp_i;

  int errors, checks, tests;
  logic [31:0] local_ref [logic [29:0]];
  logic [31:0] remote_ref [logic [29:0]];
  remote_req_s req_log [$];
  remote_req_s exp_q [$];
  logic [31:0] rng = 32'h8057;

  lsu_tile_top dut_i (.*);

  remote_mem_model net_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .net_req_i(net_req_o), .net_req_v_i(net_req_v_o),
    .net_credit_o(net_credit_i), .net_resp_o(net_resp_i), .net_resp_v_o(net_resp_v_i),
    .net_resp_yumi_i(net_resp_yumi_o), .hold_credits_i(hold_credits), .idle_o(model_idle)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    #(BUDGET * 8);
    $display("watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

  // every packet on the network, in arrival order
  always @(negedge clk_i) begin
    if (net_req_v_o) req_log.push_back(net_req_o);
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // size 0 byte, 1 halfword, 2 word
  function automatic logic [31:0] extend(input logic [31:0] w, input int size,
                                         input logic uns, input logic [1:0] lo);
    logic [31:0] v;
    if (size == 0) begin
      v = (w >> (8 * lo)) & 32'hFF;
      if (!uns && v[7]) v = v | 32'hFFFF_FF00;
    end else if (size == 1) begin
      v = (w >> (16 * lo[1])) & 32'hFFFF;
      if (!uns && v[15]) v = v | 32'hFFFF_0000;
    end else begin
      v = w;
    end
    return v;
  endfunction

  function automatic logic [3:0] lane_mask(input int size, input logic [1:0] lo);
    if (size == 0) return 4'b0001 << lo;
    if (size == 1) return lo[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  function automatic logic [31:0] lane_data(input int size, input logic [31:0] d);
    if (size == 0) return {4{d[7:0]}};
    if (size == 1) return {2{d[15:0]}};
    return d;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input int size,
                                        input logic [1:0] lo, input logic [31:0] d);
    logic [3:0] m;
    logic [31:0] ld;
    m = lane_mask(size, lo);
    ld = lane_data(size, d);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) old[8*b +: 8] = ld[8*b +: 8];
    end
    return old;
  endfunction

  // remote words never stored read back as their address pattern
  function automatic logic [31:0] remote_word(input logic [31:0] addr);
    if (remote_ref.exists(addr[31:2])) begin
      return remote_ref[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  task automatic compare_word(input string name, input logic [`DATA_WIDTH-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_reg(input string name, input logic [`REG_ADDR_WIDTH-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_req(input string name, input remote_req_s got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic present_op(input logic st, input int size, input logic uns, input logic fp,
                            input logic [31:0] addr, input logic [31:0] d, input logic [4:0] rd);
    decode_s dec;
    dec = '{is_mem_op: 1'b1, is_load_op: !st, is_store_op: st, is_byte_op: size == 0,
            is_hex_op: size == 1, is_load_unsigned: uns, op_writes_fp_rf: fp};
    @(posedge clk_i);
    exe_decode_i <= dec;
    exe_rs1_i    <= addr - 32'd16;
    mem_offset_i <= 32'd16;
    exe_rs2_i    <= d;
    exe_rd_i     <= rd;
  endtask

  // the op issues on the first edge with stall low
  task automatic finish_issue();
    int n;
    n = 0;
    @(negedge clk_i);
    while (stall_o && n < LIMIT) begin
      n++;
      @(negedge clk_i);
    end
    if (stall_o) begin
      errors++;
      $display("stall never cleared, the operation could not issue");
    end
    @(posedge clk_i);
    exe_decode_i <= '0;
  endtask

  task automatic local_store(input int size, input logic [31:0] addr, input logic [31:0] d);
    present_op(1'b1, size, 1'b0, 1'b0, addr, d, 5'd0);
    finish_issue();
    if (!local_ref.exists(addr[31:2])) local_ref[addr[31:2]] = 32'h0;
    local_ref[addr[31:2]] = merge(local_ref[addr[31:2]], size, addr[1:0], d);
  endtask

  task automatic local_load(input int size, input logic uns, input logic fp,
                            input logic [31:0] addr, input logic [4:0] rd);
    present_op(1'b0, size, uns, fp, addr, 32'h0, rd);
    finish_issue();
    @(negedge clk_i);
    compare_flag("local_load_v_o", local_load_v_o, 1'b1);
    compare_word("local_load_data_o", local_load_data_o,
                 extend(local_ref[addr[31:2]], size, uns, addr[1:0]));
    compare_reg("local_load_reg_o", local_load_reg_o, rd);
    compare_flag("local_load_float_o", local_load_float_o, fp);
    @(negedge clk_i);
    compare_flag("local_load_v_o", local_load_v_o, 1'b0);
  endtask

  // queue the packet a remote op should produce and track its store
  task automatic expect_req(input logic st, input int size, input logic uns, input logic fp,
                            input logic [31:0] addr, input logic [31:0] d,
                            input logic [4:0] rd);
    remote_req_s r;
    r.write_not_read = st;
    r.mask = lane_mask(size, addr[1:0]);
    r.addr = addr;
    if (st) begin
      r.payload.write_data = lane_data(size, d);
      remote_ref[addr[31:2]] = merge(remote_word(addr), size, addr[1:0], d);
    end else begin
      r.payload.read_info.reserved = '0;
      r.payload.read_info.load_info = '{fp, uns, size == 0, size == 1, addr[1:0], rd};
    end
    exp_q.push_back(r);
  endtask

  // issue a remote op and queue the packet it should produce
  task automatic remote_op(input logic st, input int size, input logic uns, input logic fp,
                           input logic [31:0] addr, input logic [31:0] d, input logic [4:0] rd);
    expect_req(st, size, uns, fp, addr, d, rd);
    present_op(st, size, uns, fp, addr, d, rd);
    finish_issue();
  endtask

  task automatic check_reqs();
    int n;
    n = 0;
    while (req_log.size() < exp_q.size() && n < LIMIT) begin
      n++;
      @(negedge clk_i);
    end
    if (req_log.size() != exp_q.size()) begin
      errors++;
      $display("expected %0d network packets but saw %0d", exp_q.size(), req_log.size());
    end else begin
      foreach (exp_q[i]) compare_req("net_req_o", req_log[i], exp_q[i]);
    end
    req_log.delete();
    exp_q.delete();
  endtask

  task automatic wait_resp(input logic fp);
    int n;
    n = 0;
    while (!(fp ? fp_remote_load_v_o : int_remote_load_v_o) && n < LIMIT) begin
      n++;
      @(negedge clk_i);
    end
    if (n == LIMIT) begin
      errors++;
      $display("no remote load response arrived");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!model_idle && n < LIMIT) begin
      n++;
      @(negedge clk_i);
    end
    if (!model_idle) begin
      errors++;
      $display("network still had credits or responses pending");
    end
    repeat (3) @(negedge clk_i);
  endtask

  task automatic report(input string name, input int start_errors);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - start_errors);
  endtask

  task automatic test_local_lanes();
    int e;
    logic [31:0] base;
    e = errors;
    base = 32'h0000_0200;
    for (int w = 0; w < 3; w++) begin
      rng = xorshift(rng);
      local_store(2, base + 4 * w, rng);
    end
    local_store(1, base, 32'h0000_8A11);
    local_store(1, base + 6, 32'h0000_7F22);
    for (int b = 0; b < 4; b++) local_store(0, base + 8 + b, 32'h80 + 32'h21 * b);
    for (int w = 0; w < 3; w++) begin
      for (int b = 0; b < 4; b++) begin
        local_load(0, 1'b0, 1'b0, base + 4 * w + b, 5'(b + 1));
        local_load(0, 1'b1, 1'b0, base + 4 * w + b, 5'(b + 5));
      end
      local_load(1, 1'b0, 1'b0, base + 4 * w, 5'd10);
      local_load(1, 1'b1, 1'b0, base + 4 * w + 2, 5'd11);
      local_load(1, 1'b0, 1'b0, base + 4 * w + 2, 5'd12);
      local_load(2, 1'b0, 1'b1, base + 4 * w, 5'd31);
    end
    report("local lanes", e);
  endtask

  task automatic test_remote_int();
    int e;
    e = errors;
    remote_op(1'b1, 2, 1'b0, 1'b0, 32'h0002_0100, 32'h89AB_CDEF, 5'd0);
    remote_op(1'b0, 1, 1'b0, 1'b0, 32'h0002_0102, 32'h0, 5'd7);
    check_reqs();
    wait_resp(1'b0);
    // held until execute takes it
    compare_flag("net_resp_yumi_o", net_resp_yumi_o, 1'b0);
    @(posedge clk_i);
    int_remote_load_yumi_i <= 1'b1;
    @(negedge clk_i);
    compare_flag("int_remote_load_v_o", int_remote_load_v_o, 1'b1);
    compare_word("int_remote_load_data_o", int_remote_load_data_o,
                 extend(remote_word(32'h0002_0102), 1, 1'b0, 2'b10));
    compare_flag("net_resp_yumi_o", net_resp_yumi_o, 1'b1);
    compare_flag("int_remote_load_force_o", int_remote_load_force_o, 1'b0);
    compare_flag("fp_remote_load_v_o", fp_remote_load_v_o, 1'b0);
    @(negedge clk_i);
    compare_flag("int_remote_load_v_o", int_remote_load_v_o, 1'b0);
    @(posedge clk_i);
    int_remote_load_yumi_i <= 1'b0;
    report("remote integer load", e);
  endtask

  task automatic test_remote_fp();
    int e;
    e = errors;
    remote_op(1'b0, 2, 1'b0, 1'b1, 32'h0003_0040, 32'h0, 5'd3);
    check_reqs();
    wait_resp(1'b1);
    compare_word("fp_remote_load_data_o", fp_remote_load_data_o, remote_word(32'h0003_0040));
    compare_flag("net_resp_yumi_o", net_resp_yumi_o, 1'b1);
    compare_flag("int_remote_load_v_o", int_remote_load_v_o, 1'b0);
    report("remote fp load", e);
  endtask

  task automatic test_credits();
    int e;
    e = errors;
    wait_idle();
    hold_credits <= 1'b1;
    for (int i = 0; i < `NET_CREDITS; i++) begin
      remote_op(1'b1, 2, 1'b0, 1'b0, 32'h0004_0000 + 4 * i, 32'h1111_0000 + i, 5'd0);
    end
    present_op(1'b1, 2, 1'b0, 1'b0, 32'h0004_0100, 32'h5555_AAAA, 5'd0);
    repeat (6) begin
      @(negedge clk_i);
      compare_flag("stall_o", stall_o, 1'b1);
    end
    hold_credits <= 1'b0;
    expect_req(1'b1, 2, 1'b0, 1'b0, 32'h0004_0100, 32'h5555_AAAA, 5'd0);
    finish_issue();
    check_reqs();
    report("credit exhaustion", e);
  endtask

  task automatic test_force();
    int e;
    e = errors;
    @(posedge clk_i);
    resp_force_i <= 1'b1;
    int_remote_load_yumi_i <= 1'b0;
    remote_op(1'b0, 1, 1'b1, 1'b0, 32'h0002_0100, 32'h0, 5'd9);
    check_reqs();
    wait_resp(1'b0);
    compare_word("int_remote_load_data_o", int_remote_load_data_o,
                 extend(remote_word(32'h0002_0100), 1, 1'b1, 2'b00));
    compare_flag("int_remote_load_force_o", int_remote_load_force_o, 1'b1);
    compare_flag("net_resp_yumi_o", net_resp_yumi_o, 1'b1);
    @(negedge clk_i);
    compare_flag("int_remote_load_v_o", int_remote_load_v_o, 1'b0);
    @(posedge clk_i);
    resp_force_i <= 1'b0;
    report("forced write-back", e);
  endtask

  task automatic test_boundary();
    int e;
    e = errors;
    wait_idle();
    req_log.delete();
    local_store(2, 32'h0000_0FFC, 32'hC0DE_F00D);
    repeat (3) @(negedge clk_i);
    compare_word("net packets", req_log.size(), 32'd0);
    local_load(2, 1'b0, 1'b0, 32'h0000_0FFC, 5'd4);
    remote_op(1'b1, 2, 1'b0, 1'b0, 32'h0000_1000, 32'h0BAD_CAFE, 5'd0);
    check_reqs();
    report("address boundary", e);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    tests = 0;
    arst_n_i = 1'b0;
    exe_decode_i = '0;
    exe_rs1_i = '0;
    exe_rs2_i = '0;
    exe_rd_i = '0;
    mem_offset_i = '0;
    resp_force_i = 1'b0;
    int_remote_load_yumi_i = 1'b0;
    hold_credits = 1'b0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    compare_flag("net_req_v_o", net_req_v_o, 1'b0);
    compare_flag("local_load_v_o", local_load_v_o, 1'b0);
    compare_flag("stall_o", stall_o, 1'b0);
    test_local_lanes();
    test_remote_int();
    test_remote_fp();
    test_credits();
    test_force();
    test_boundary();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
